// File: kernel_cfg.svh
`ifndef KERNEL_CFG_SVH
`define KERNEL_CFG_SVH

`define KERNEL_ADDR_W     64
`define KERNEL_DATA_W     128
`define KERNEL_ID_W       4
`define KERNEL_HOST_AW    15
`define KERNEL_BUF_WORDS  8   // 32-bit words in the staging buffer
`define KERNEL_LOG2_DEPTH 4   // 16 entries per queue

// fixed request attributes
`define KERNEL_AWID       1
`define KERNEL_ARID       2
`define KERNEL_BURST_INCR 1

`define REG_DATA0        15'h000  // word i sits at +4*i
`define REG_AW_PUSH      15'h020
`define REG_W_PUSH       15'h030
`define REG_AR_PUSH      15'h040
`define REG_B_STAT       15'h050
`define REG_B_POP        15'h054
`define REG_R_STAT       15'h060
`define REG_R_POP        15'h064
`define REG_LINK_RST_SET 15'h0c0
`define REG_LINK_RST_CLR 15'h0c4

`endif

// File: kernel_pkg.sv
`include "kernel_cfg.svh"

package kernel_pkg;

  // one host port access, sampled every clk
  typedef struct packed {
    logic                       en;
    logic [3:0]                 we;
    logic [`KERNEL_HOST_AW-1:0] addr;
    logic [31:0]                din;
  } host_req_t;

  // field order matches the buffer packing, addr in the low bits
  typedef struct packed {
    logic [2:0]                size;
    logic [`KERNEL_ADDR_W-1:0] addr;
  } aw_req_t;

  typedef struct packed {
    logic [2:0]                size;
    logic [`KERNEL_ADDR_W-1:0] addr;
  } ar_req_t;

  typedef struct packed {
    logic [`KERNEL_DATA_W/8-1:0] strb;
    logic [`KERNEL_DATA_W-1:0]   data;
  } w_beat_t;

  typedef struct packed {
    logic [`KERNEL_ID_W-1:0] id;
    logic [1:0]              resp;
  } b_resp_t;

  typedef struct packed {
    logic [`KERNEL_ID_W-1:0]   id;
    logic [1:0]                resp;
    logic [`KERNEL_DATA_W-1:0] data;
  } r_beat_t;

endpackage

// File: fifo_bp.sv
`timescale 1ns/1ps

module fifo_bp #(
  parameter type payload_t  = logic [31:0],
  parameter int  LOG2_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     wvalid,
  input  payload_t wdata,
  output logic     wready,
  output logic     rvalid,
  output payload_t rdata,
  input  logic     rready
);

  localparam int DEPTH = 1 << LOG2_DEPTH;

  payload_t            mem [DEPTH];
  logic [LOG2_DEPTH:0] wr_ptr;  // msb tells wrap
  logic [LOG2_DEPTH:0] wr_vis;  // wr_ptr one edge late, bounds what the head may show
  logic [LOG2_DEPTH:0] rd_ptr;
  logic [LOG2_DEPTH:0] count;
  logic                push;
  logic                pop;

  assign wready = (count != (LOG2_DEPTH + 1)'(DEPTH));
  assign rvalid = (rd_ptr != wr_vis);
  assign rdata  = mem[rd_ptr[LOG2_DEPTH-1:0]];
  assign push   = wvalid & wready;  // full queue drops the push
  assign pop    = rvalid & rready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      wr_vis <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_vis <= wr_ptr;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr[LOG2_DEPTH-1:0]] <= wdata;
  end

endmodule

// File: host_regs.sv
`timescale 1ns/1ps
`include "kernel_cfg.svh"

module host_regs
  import kernel_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  host_req_t   host,
  output logic [31:0] host_dout,
  output logic        ocu_rstn,
  output logic        aw_push,
  output aw_req_t     aw_req,
  output logic        w_push,
  output w_beat_t     w_beat,
  output logic        ar_push,
  output ar_req_t     ar_req,
  output logic        b_pop,
  input  b_resp_t     b_head,
  input  logic        b_avail,
  output logic        r_pop,
  input  r_beat_t     r_head,
  input  logic        r_avail
);

  localparam int BUF_W  = `KERNEL_BUF_WORDS * 32;
  localparam int WIDX_W = $clog2(`KERNEL_BUF_WORDS);
  localparam logic [`KERNEL_HOST_AW-1:0] BUF_SPAN = `KERNEL_HOST_AW'(4 * `KERNEL_BUF_WORDS);

  logic [BUF_W-1:0]           data_buf;
  logic [`KERNEL_HOST_AW-1:0] word_off;
  logic [WIDX_W-1:0]          widx;
  logic                       is_word;
  logic                       wr_cycle;
  logic                       rd_cycle;
  logic                       hit_aw;
  logic                       hit_w;
  logic                       hit_ar;
  logic                       hit_bpop;
  logic                       hit_rpop;
  logic                       link_rstn_sw;
  logic [31:0]                rd_val;

  assign wr_cycle = host.en && (host.we != 4'b0);
  assign rd_cycle = host.en && (host.we == 4'b0);
  assign word_off = host.addr - `REG_DATA0;
  assign widx     = word_off[2 +: WIDX_W];
  assign is_word  = (word_off < BUF_SPAN) && (word_off[1:0] == 2'b00);

  assign hit_aw   = wr_cycle && (host.addr == `REG_AW_PUSH);
  assign hit_w    = wr_cycle && (host.addr == `REG_W_PUSH);
  assign hit_ar   = wr_cycle && (host.addr == `REG_AR_PUSH);
  // one pop per waiting entry, a pop already in flight blocks the next
  assign hit_bpop = wr_cycle && (host.addr == `REG_B_POP) && b_avail && !b_pop;
  assign hit_rpop = wr_cycle && (host.addr == `REG_R_POP) && r_avail && !r_pop;

  always_comb begin
    rd_val = '0;
    if (is_word) begin
      rd_val = data_buf[widx*32 +: 32];
    end else begin
      case (host.addr)
        `REG_B_STAT: rd_val = {31'b0, b_avail & ~b_pop};  // pending pop reads as gone
        `REG_R_STAT: rd_val = {31'b0, r_avail & ~r_pop};
        default:     rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push      <= 1'b0;
      w_push       <= 1'b0;
      ar_push      <= 1'b0;
      b_pop        <= 1'b0;
      r_pop        <= 1'b0;
      link_rstn_sw <= 1'b1;
      ocu_rstn     <= 1'b0;
      host_dout    <= '0;
    end else begin
      aw_push  <= hit_aw;
      w_push   <= hit_w;
      ar_push  <= hit_ar;
      b_pop    <= hit_bpop;
      r_pop    <= hit_rpop;
      ocu_rstn <= link_rstn_sw;  // link follows one edge behind
      if (wr_cycle && (host.addr == `REG_LINK_RST_SET)) link_rstn_sw <= 1'b0;
      else if (wr_cycle && (host.addr == `REG_LINK_RST_CLR)) link_rstn_sw <= 1'b1;
      if (rd_cycle) host_dout <= rd_val;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_cycle && is_word) begin
      for (int i = 0; i < 4; i++) begin
        if (host.we[i]) data_buf[widx*32 + i*8 +: 8] <= host.din[i*8 +: 8];  // byte lanes
      end
    end
    if (hit_bpop) data_buf <= BUF_W'(b_head);
    if (hit_rpop) data_buf <= BUF_W'(r_head);
    if (hit_aw) aw_req <= aw_req_t'(data_buf[$bits(aw_req_t)-1:0]);
    if (hit_w) w_beat <= w_beat_t'(data_buf[$bits(w_beat_t)-1:0]);
    if (hit_ar) ar_req <= ar_req_t'(data_buf[$bits(ar_req_t)-1:0]);
  end

endmodule

// File: axi_master_port.sv
`timescale 1ns/1ps
`include "kernel_cfg.svh"

module axi_master_port
  import kernel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    aw_push,
  input  aw_req_t                 aw_req,
  input  logic                    w_push,
  input  w_beat_t                 w_beat,
  input  logic                    ar_push,
  input  ar_req_t                 ar_req,
  input  logic                    b_pop,
  output b_resp_t                 b_head,
  output logic                    b_avail,
  input  logic                    r_pop,
  output r_beat_t                 r_head,
  output logic                    r_avail,
  output logic                    awvalid,
  input  logic                    awready,
  output aw_req_t                 aw,
  output logic [`KERNEL_ID_W-1:0] awid,
  output logic [7:0]              awlen,
  output logic [1:0]              awburst,
  output logic                    wvalid,
  input  logic                    wready,
  output w_beat_t                 w,
  output logic                    wlast,
  output logic                    arvalid,
  input  logic                    arready,
  output ar_req_t                 ar,
  output logic [`KERNEL_ID_W-1:0] arid,
  output logic [7:0]              arlen,
  output logic [1:0]              arburst,
  input  logic                    bvalid,
  output logic                    bready,
  input  b_resp_t                 b,
  input  logic                    rvalid,
  output logic                    rready,
  input  r_beat_t                 r
);

  // single-beat INCR bursts with fixed ids
  assign awid    = `KERNEL_ID_W'(`KERNEL_AWID);
  assign awlen   = 8'd0;
  assign awburst = 2'(`KERNEL_BURST_INCR);
  assign wlast   = 1'b1;
  assign arid    = `KERNEL_ID_W'(`KERNEL_ARID);
  assign arlen   = 8'd0;
  assign arburst = 2'(`KERNEL_BURST_INCR);

  fifo_bp #(.payload_t(aw_req_t), .LOG2_DEPTH(`KERNEL_LOG2_DEPTH)) aw_q (
    .clk, .rstn,
    .wvalid(aw_push), .wdata(aw_req), .wready(),
    .rvalid(awvalid), .rdata(aw), .rready(awready)
  );

  fifo_bp #(.payload_t(w_beat_t), .LOG2_DEPTH(`KERNEL_LOG2_DEPTH)) w_q (
    .clk, .rstn,
    .wvalid(w_push), .wdata(w_beat), .wready(),
    .rvalid(wvalid), .rdata(w), .rready(wready)
  );

  fifo_bp #(.payload_t(ar_req_t), .LOG2_DEPTH(`KERNEL_LOG2_DEPTH)) ar_q (
    .clk, .rstn,
    .wvalid(ar_push), .wdata(ar_req), .wready(),
    .rvalid(arvalid), .rdata(ar), .rready(arready)
  );

  // inbound side, ready drops when the queue fills
  fifo_bp #(.payload_t(b_resp_t), .LOG2_DEPTH(`KERNEL_LOG2_DEPTH)) b_q (
    .clk, .rstn,
    .wvalid(bvalid), .wdata(b), .wready(bready),
    .rvalid(b_avail), .rdata(b_head), .rready(b_pop)
  );

  fifo_bp #(.payload_t(r_beat_t), .LOG2_DEPTH(`KERNEL_LOG2_DEPTH)) r_q (
    .clk, .rstn,
    .wvalid(rvalid), .wdata(r), .wready(rready),
    .rvalid(r_avail), .rdata(r_head), .rready(r_pop)
  );

endmodule

// File: kernel.sv
`timescale 1ns/1ps
`include "kernel_cfg.svh"

module kernel
  import kernel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rstn,
  input  host_req_t               host,
  output logic [31:0]             host_dout,
  output logic                    ocu_rstn,
  output logic                    awvalid,
  input  logic                    awready,
  output aw_req_t                 aw,
  output logic [`KERNEL_ID_W-1:0] awid,
  output logic [7:0]              awlen,
  output logic [1:0]              awburst,
  output logic                    wvalid,
  input  logic                    wready,
  output w_beat_t                 w,
  output logic                    wlast,
  output logic                    arvalid,
  input  logic                    arready,
  output ar_req_t                 ar,
  output logic [`KERNEL_ID_W-1:0] arid,
  output logic [7:0]              arlen,
  output logic [1:0]              arburst,
  input  logic                    bvalid,
  output logic                    bready,
  input  b_resp_t                 b,
  input  logic                    rvalid,
  output logic                    rready,
  input  r_beat_t                 r
);

  logic    aw_push;
  aw_req_t aw_req;
  logic    w_push;
  w_beat_t w_beat;
  logic    ar_push;
  ar_req_t ar_req;
  logic    b_pop;
  b_resp_t b_head;
  logic    b_avail;
  logic    r_pop;
  r_beat_t r_head;
  logic    r_avail;

  host_regs host_regs_inst (
    .clk, .rstn, .host, .host_dout, .ocu_rstn,
    .aw_push, .aw_req, .w_push, .w_beat, .ar_push, .ar_req,
    .b_pop, .b_head, .b_avail, .r_pop, .r_head, .r_avail
  );

  axi_master_port axi_master_port_inst (
    .clk, .rstn,
    .aw_push, .aw_req, .w_push, .w_beat, .ar_push, .ar_req,
    .b_pop, .b_head, .b_avail, .r_pop, .r_head, .r_avail,
    .awvalid, .awready, .aw, .awid, .awlen, .awburst,
    .wvalid, .wready, .w, .wlast,
    .arvalid, .arready, .ar, .arid, .arlen, .arburst,
    .bvalid, .bready, .b,
    .rvalid, .rready, .r
  );

endmodule

// File: kernel_sva.sv
`timescale 1ns/1ps

module kernel_sva
  import kernel_pkg::*;
(
  input logic    clk,
  input logic    rstn,
  input logic    ocu_rstn,
  input logic    awvalid,
  input logic    awready,
  input aw_req_t aw,
  input logic    wvalid,
  input logic    wready,
  input w_beat_t w,
  input logic    arvalid
);

  // stalled beats hold their payload
  aw_stable: assert property (@(posedge clk) disable iff (!rstn)
    awvalid && !awready |=> awvalid && $stable(aw))
    else $error("AW payload changed while stalled");

  w_stable: assert property (@(posedge clk) disable iff (!rstn)
    wvalid && !wready |=> wvalid && $stable(w))
    else $error("W payload changed while stalled");

  quiet_in_reset: assert property (@(posedge clk) !rstn |-> !awvalid && !wvalid && !arvalid)
    else $error("request valid high during reset");

  link_in_reset: assert property (@(posedge clk) !rstn |-> !ocu_rstn)
    else $error("ocu_rstn high during reset");

endmodule

bind kernel kernel_sva kernel_sva_inst (.*);

// File: kernel_checker.sv
`timescale 1ns/1ps
`include "kernel_cfg.svh"

module kernel_checker
  import kernel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rstn,
  input  host_req_t               host,
  input  logic [31:0]             host_dout,
  input  logic                    ocu_rstn,
  input  logic                    awvalid,
  input  logic                    awready,
  input  aw_req_t                 aw,
  input  logic [`KERNEL_ID_W-1:0] awid,
  input  logic [7:0]              awlen,
  input  logic [1:0]              awburst,
  input  logic                    wvalid,
  input  logic                    wready,
  input  w_beat_t                 w,
  input  logic                    wlast,
  input  logic                    arvalid,
  input  logic                    arready,
  input  ar_req_t                 ar,
  input  logic [`KERNEL_ID_W-1:0] arid,
  input  logic [7:0]              arlen,
  input  logic [1:0]              arburst,
  input  logic                    bvalid,
  input  logic                    bready,
  input  b_resp_t                 b,
  input  logic                    rvalid,
  input  logic                    rready,
  input  r_beat_t                 r,
  input  logic [1:0]              exp_op,  // 1 read compare, 2 link level
  input  logic [31:0]             exp_val,
  input  int                      test_idx,
  output int                      errors
);

  logic [`KERNEL_BUF_WORDS*32-1:0] model_buf;  // mirror of the staging buffer
  aw_req_t                         aw_exp[$];
  w_beat_t                         w_exp[$];
  ar_req_t                         ar_exp[$];
  int                              aw_tidx[$];
  int                              w_tidx[$];
  int                              ar_tidx[$];
  b_resp_t                         b_sent[$];
  r_beat_t                         r_sent[$];
  logic                            rd_pend = 1'b0;
  logic [31:0]                     rd_exp;
  int                              rd_tidx;
  int                              err_cnt = 0;

  assign errors = err_cnt;

  function automatic string test_name(int idx);
    case (idx)
      1: return "buf_rw";
      2: return "aw_push";
      3: return "w_push";
      4: return "ar_push";
      5: return "b_resp";
      6: return "r_resp";
      7: return "link_rst";
      8: return "aw_stall";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(int idx, string what, logic [255:0] exp, logic [255:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name(idx), what, exp, act);
    end
  endtask

  task automatic extra_request(string chan);
    err_cnt++;
    $display("%s request reached the slave with no matching push", chan);
  endtask

  // mirror host writes into the model buffer and the expected requests
  task automatic track_write();
    aw_req_t a;
    ar_req_t q;
    w_beat_t wb;
    b_resp_t bb;
    r_beat_t rb;
    a.addr  = model_buf[63:0];   // words 0 and 1
    a.size  = model_buf[66:64];
    q.addr  = model_buf[63:0];
    q.size  = model_buf[66:64];
    wb.data = model_buf[127:0];
    wb.strb = model_buf[143:128];  // low half of word 4
    if (host.addr < 15'h020 && host.addr[1:0] == 2'b00) begin
      for (int i = 0; i < 4; i++) begin
        if (host.we[i]) model_buf[host.addr[4:2]*32 + i*8 +: 8] = host.din[i*8 +: 8];
      end
    end
    case (host.addr)
      `REG_AW_PUSH: begin
        aw_exp.push_back(a);
        aw_tidx.push_back(test_idx);
      end
      `REG_W_PUSH: begin
        w_exp.push_back(wb);
        w_tidx.push_back(test_idx);
      end
      `REG_AR_PUSH: begin
        ar_exp.push_back(q);
        ar_tidx.push_back(test_idx);
      end
      `REG_B_POP: if (b_sent.size() > 0) begin
        bb = b_sent.pop_front();
        model_buf = '0;
        model_buf[5:0] = {bb.id, bb.resp};
      end
      `REG_R_POP: if (r_sent.size() > 0) begin
        rb = r_sent.pop_front();
        model_buf = '0;
        model_buf[127:0] = rb.data;
        model_buf[133:128] = {rb.id, rb.resp};
      end
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    int tidx;
    if (rd_pend) compare(rd_tidx, "host_dout", rd_exp, host_dout);
    rd_pend <= exp_op == 2'd1 && host.en && host.we == 4'b0;
    rd_exp  <= exp_val;
    rd_tidx <= test_idx;
    if (exp_op == 2'd2) compare(test_idx, "ocu_rstn", exp_val[0], ocu_rstn);
    if (bvalid && bready) b_sent.push_back(b);
    if (rvalid && rready) r_sent.push_back(r);
    if (rstn && host.en && host.we != 4'b0) track_write();
    if (awvalid && awready) begin
      if (aw_exp.size() == 0) begin
        extra_request("AW");
      end else begin
        tidx = aw_tidx.pop_front();
        compare(tidx, "aw", aw_exp.pop_front(), aw);
        compare(tidx, "awid awlen awburst", {4'd1, 8'd0, 2'd1}, {awid, awlen, awburst});
      end
    end
    if (wvalid && wready) begin
      if (w_exp.size() == 0) begin
        extra_request("W");
      end else begin
        tidx = w_tidx.pop_front();
        compare(tidx, "w", w_exp.pop_front(), w);
        compare(tidx, "wlast", 1'b1, wlast);
      end
    end
    if (arvalid && arready) begin
      if (ar_exp.size() == 0) begin
        extra_request("AR");
      end else begin
        tidx = ar_tidx.pop_front();
        compare(tidx, "ar", ar_exp.pop_front(), ar);
        compare(tidx, "arid arlen arburst", {4'd2, 8'd0, 2'd1}, {arid, arlen, arburst});
      end
    end
  end

endmodule

// File: tb_kernel.sv
`timescale 1ns/1ps
`include "kernel_cfg.svh"

module tb_kernel
  import kernel_pkg::*;
();

  localparam int TIMEOUT = 2000;  // cycles per wait

  logic                    clk = 1'b0;
  logic                    rstn;
  host_req_t               host;
  logic [31:0]             host_dout;
  logic                    ocu_rstn;
  logic                    awvalid;
  logic                    awready = 1'b0;
  aw_req_t                 aw;
  logic [`KERNEL_ID_W-1:0] awid;
  logic [7:0]              awlen;
  logic [1:0]              awburst;
  logic                    wvalid;
  logic                    wready = 1'b0;
  w_beat_t                 w;
  logic                    wlast;
  logic                    arvalid;
  logic                    arready = 1'b0;
  ar_req_t                 ar;
  logic [`KERNEL_ID_W-1:0] arid;
  logic [7:0]              arlen;
  logic [1:0]              arburst;
  logic                    bvalid;
  logic                    bready;
  b_resp_t                 b;
  logic                    rvalid;
  logic                    rready;
  r_beat_t                 r;
  logic [1:0]              exp_op;
  logic [31:0]             exp_val;
  int                      test_idx;
  int                      value_errors;
  int                      fault_count = 0;
  int                      pushed = 0;
  logic [31:0]             rnd = 32'd61;
  aw_req_t                 aw_seen[$];
  w_beat_t                 w_seen[$];
  ar_req_t                 ar_seen[$];

  always #5 clk = ~clk;

  kernel kernel_inst (.*);

  kernel_checker checker_inst (.*, .errors(value_errors));

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // slave side, random stalls on the request channels
  always @(posedge clk) begin
    rnd     <= xorshift(rnd);
    awready <= rnd[0];
    wready  <= rnd[1];
    arready <= rnd[2];
    if (awvalid && awready) aw_seen.push_back(aw);
    if (wvalid && wready) w_seen.push_back(w);
    if (arvalid && arready) ar_seen.push_back(ar);
  end

  task automatic host_access(logic [3:0] we, logic [14:0] addr, logic [31:0] din,
                             logic [1:0] op, logic [31:0] expv);
    @(posedge clk);
    host    <= '{en: 1'b1, we: we, addr: addr, din: din};
    exp_op  <= op;
    exp_val <= expv;
    @(posedge clk);
    host    <= '0;
    exp_op  <= 2'd0;
  endtask

  task automatic expect_link(logic level);
    @(posedge clk);
    exp_op  <= 2'd2;
    exp_val <= {31'b0, level};
    @(posedge clk);
    exp_op  <= 2'd0;
  endtask

  task automatic send_resp(logic is_r, logic [3:0] id, logic [1:0] resp, logic [31:0] base);
    int n;
    @(posedge clk);
    if (is_r) begin
      rvalid <= 1'b1;
      r      <= '{id: id, resp: resp, data: {base + 32'd3, base + 32'd2, base + 32'd1, base}};
    end else begin
      bvalid <= 1'b1;
      b      <= '{id: id, resp: resp};
    end
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (is_r ? rready : bready) break;
    end
    bvalid <= 1'b0;
    rvalid <= 1'b0;
    if (n == TIMEOUT) begin
      fault_count++;
      $display("response beat never accepted by the DUT (id %0h)", id);
    end
  endtask

  task automatic drain();
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      if (aw_seen.size() + w_seen.size() + ar_seen.size() == pushed) break;
      @(posedge clk);
    end
    if (n == TIMEOUT) begin
      fault_count++;
      $display("only %0d of %0d pushed requests reached the slave",
               aw_seen.size() + w_seen.size() + ar_seen.size(), pushed);
    end
  endtask

  initial begin
    int          fd;
    int          cnt;
    int          tidx;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    rstn     = 1'b0;
    host     = '0;
    bvalid   = 1'b0;
    b        = '0;
    rvalid   = 1'b0;
    r        = '0;
    exp_op   = 2'd0;
    exp_val  = '0;
    test_idx = 0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    fd = $fopen("kernel_input.txt", "r");
    if (fd == 0) begin
      fault_count++;
      $display("could not open kernel_input.txt");
    end else begin
      while (!$feof(fd)) begin
        cnt = $fgets(line, fd);
        if (cnt == 0 || line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%h %h %h %h %h", tidx, op, addr, data, expv) != 5) begin
          fault_count++;
          $display("malformed stimulus line: %s", line);
          continue;
        end
        test_idx <= tidx;
        case (op)
          1: begin
            host_access(4'hf, addr[14:0], data, 2'd0, '0);
            if (addr == `REG_AW_PUSH || addr == `REG_W_PUSH || addr == `REG_AR_PUSH) pushed++;
          end
          2: host_access(4'h0, addr[14:0], '0, 2'd1, expv);
          3: send_resp(1'b0, addr[3:0], data[1:0], '0);
          4: send_resp(1'b1, addr[3:0], expv[1:0], data);
          5: expect_link(expv[0]);
          6: drain();
          default: begin
            fault_count++;
            $display("unknown operation %0h in stimulus file", op);
          end
        endcase
      end
      $fclose(fd);
    end
    drain();
    repeat (3) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, fault_count);
    if (value_errors == 0 && fault_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: kernel_input.txt
# test op addr data expect, all hex
# op 1 write, 2 read, 3 B beat (addr=id data=resp), 4 R beat (addr=id, word i=data+i,
# expect=resp), 5 ocu_rstn level in expect, 6 wait until pushed requests reach the slave
1 1 00 12345678 0
1 1 04 9abcdef0 0
1 1 08 00000005 0
1 1 0c deadbeef 0
1 1 10 0000a5c3 0
1 1 14 55aa55aa 0
1 1 18 0f0f0f0f 0
1 1 1c cafef00d 0
1 2 00 0 12345678
1 2 04 0 9abcdef0
1 2 08 0 00000005
1 2 0c 0 deadbeef
1 2 10 0 0000a5c3
1 2 14 0 55aa55aa
1 2 18 0 0f0f0f0f
1 2 1c 0 cafef00d
2 1 20 1 0
3 1 30 1 0
4 1 40 1 0
4 6 0 0 0
5 3 3 2 0
5 2 50 0 1
5 1 54 1 0
5 2 00 0 e
5 2 04 0 0
5 2 50 0 0
6 4 5 10203040 1
6 2 60 0 1
6 1 64 1 0
6 2 00 0 10203040
6 2 0c 0 10203043
6 2 10 0 15
6 2 14 0 0
6 2 60 0 0
7 5 0 0 1
7 1 c0 1 0
7 5 0 0 0
7 1 c4 1 0
7 5 0 0 1
8 1 00 00001000 0
8 1 20 1 0
8 1 00 00002000 0
8 1 20 1 0
8 1 00 00003000 0
8 1 20 1 0
8 1 00 00004000 0
8 1 20 1 0
8 6 0 0 0

// File: sim.f
+incdir+.
kernel_pkg.sv
fifo_bp.sv
host_regs.sv
axi_master_port.sv
kernel.sv
kernel_sva.sv
kernel_checker.sv
tb_kernel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_kernel
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "make test    build with Verilator, run the simulation, check $(LOG)"
	@echo "make clean   remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
